// File: hw/chipset_pkg.sv
// chipset bus shared definitions
package chipset_pkg;

	// ----------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------
	localparam int DATA_W     = 16;    // cpu and sram data bus
	localparam int ADDR_W     = 23;    // cpu word address, byte bits 23..1
	localparam int RAM_ADDR_W = 21;    // sram word address, 8 x 512KB
	localparam int BANK_W     = 8;     // one-hot bank select
	localparam int IRQ_W      = 14;    // interrupt request sources

	// ----------------------------------------------------------
	// memory map, byte addresses
	// ----------------------------------------------------------
	localparam logic [23:0] CHIP_BASE = 24'h000000;  // chip ram, up to 2MB
	localparam logic [23:0] SLOW_BASE = 24'hC00000;  // slow ram, up to 1.5MB
	localparam logic [23:0] KICK_BASE = 24'hF80000;  // kickstart rom to top
	localparam logic [23:0] REG_BASE  = 24'hDFF000;  // custom registers, 512 bytes

	// ----------------------------------------------------------
	// custom register offsets from REG_BASE
	// ----------------------------------------------------------
	localparam logic [8:0] INTENAR = 9'h01C;  // enable read
	localparam logic [8:0] INTREQR = 9'h01E;  // request read
	localparam logic [8:0] INTENA  = 9'h09A;  // enable write
	localparam logic [8:0] INTREQ  = 9'h09C;  // request write

	// register bit positions
	localparam int INTEN_BIT  = 14;  // master interrupt enable
	localparam int SETCLR_BIT = 15;  // 1 sets, 0 clears

	// ----------------------------------------------------------
	// sram bank layout
	// ----------------------------------------------------------
	// chip ram takes banks 0..3, slow ram follows,
	// kickstart sits in the last bank
	localparam int BANK_SLOW0 = 4;  // first slow bank
	localparam int BANK_KICK  = 7;  // rom image bank

endpackage

// File: hw/cpu_bus_bridge.sv
// 68000 bus cycle bridge
`timescale 1ns/1ps

module cpu_bus_bridge #(
	parameter int ACCESS_CYCLES = 2  // clocks of rd strobe
) (
	input  logic clk,
	input  logic reset,
	input  logic _cpu_as_i,   // address strobe
	input  logic _cpu_uds_i,  // upper byte strobe
	input  logic _cpu_lds_i,  // lower byte strobe
	input  logic cpu_r_w_i,   // 1 read, 0 write
	input  logic [chipset_pkg::DATA_W-1:0] ram_rd_data_i,
	input  logic [chipset_pkg::DATA_W-1:0] reg_rd_data_i,
	output logic rd_o,
	output logic hwr_o,
	output logic lwr_o,
	output logic [chipset_pkg::DATA_W-1:0] cpu_rdata_o,
	output logic _cpu_dtack_o
);

	localparam int CNT_W = $clog2(ACCESS_CYCLES + 1);
	// fsm states
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_STROBE = 2'd1;  // strobes out, counting
	localparam logic [1:0] ST_ACK    = 2'd2;  // dtack low, wait for as release

	logic [1:0] state;
	logic [CNT_W-1:0] cnt;  // edges since cycle start, minus one
	logic cnt_first, cnt_last;

	assign cnt_first = (cnt == '0);                     // edge 1
	assign cnt_last  = (cnt == CNT_W'(ACCESS_CYCLES));  // edge ACCESS_CYCLES+1

	// ----------------------------------------------------------
	// cycle sequencer
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cnt <= '0;
			rd_o <= 1'b0;
			hwr_o <= 1'b0;
			lwr_o <= 1'b0;
			_cpu_dtack_o <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (!_cpu_as_i)
						state <= ST_STROBE;  // edge 0
				end
				ST_STROBE: begin
					cnt <= cnt + 1'b1;
					// byte writes are single clock pulses
					hwr_o <= cnt_first & ~cpu_r_w_i & ~_cpu_uds_i;
					lwr_o <= cnt_first & ~cpu_r_w_i & ~_cpu_lds_i;
					if (cnt_first)
						rd_o <= cpu_r_w_i;
					if (cnt_last) begin
						rd_o <= 1'b0;
						_cpu_dtack_o <= 1'b0;
						state <= ST_ACK;
					end
				end
				ST_ACK: if (_cpu_as_i) begin  // cpu let go
					_cpu_dtack_o <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read data capture at acknowledge, sources are zero when idle
	always_ff @(posedge clk) begin
		if (state == ST_STROBE && cnt_last)
			cpu_rdata_o <= ram_rd_data_i | reg_rd_data_i;
	end

endmodule

// File: hw/address_decoder.sv
// memory map decoder
`timescale 1ns/1ps

module address_decoder (
	input  logic [chipset_pkg::ADDR_W-1:0] address_i,  // byte bits 23..1
	input  logic rd_i,
	input  logic [3:0] memory_config_i,
	input  logic ovl_i,
	output logic [3:0] sel_chip_o,  // chip ram 512KB banks
	output logic [2:0] sel_slow_o,  // slow ram 512KB banks
	output logic sel_kick_o,        // kickstart rom
	output logic sel_reg_o          // custom registers
);

	logic [chipset_pkg::ADDR_W:0] byte_addr;
	logic [chipset_pkg::ADDR_W:0] chip_off;  // offset into chip region
	logic [chipset_pkg::ADDR_W:0] slow_off;  // offset into slow region
	logic in_chip, in_slow;
	logic [1:0] chip_bank, slow_bank;
	logic ovl_hit;  // read redirected to rom

	assign byte_addr = {address_i, 1'b0};
	assign chip_off  = byte_addr - chipset_pkg::CHIP_BASE;
	assign slow_off  = byte_addr - chipset_pkg::SLOW_BASE;

	// both regions span at most 4 x 512KB
	assign in_chip   = (chip_off[23:21] == 3'd0);
	assign in_slow   = (slow_off[23:21] == 3'd0);
	assign chip_bank = chip_off[20:19];
	assign slow_bank = slow_off[20:19];

	// overlay only steals reads, writes still land in chip ram
	assign ovl_hit = ovl_i & rd_i & in_chip & (chip_bank == 2'd0);

	// ----------------------------------------------------------
	// sized ram selects
	// ----------------------------------------------------------
	always_comb begin
		for (int n = 0; n < 4; n++) begin
			sel_chip_o[n] = in_chip & (chip_bank == 2'(n))
				& (2'(n) <= memory_config_i[1:0])  // chip banks = cfg + 1
				& ~((n == 0) & ovl_hit);
		end
		for (int n = 0; n < 3; n++) begin
			sel_slow_o[n] = in_slow & (slow_bank == 2'(n))
				& (2'(n) < memory_config_i[3:2]);  // 0 means no slow ram
		end
	end

	// rom runs from base to the top of the map
	assign sel_kick_o = (byte_addr >= chipset_pkg::KICK_BASE) | ovl_hit;
	assign sel_reg_o  = (byte_addr[23:9] == chipset_pkg::REG_BASE[23:9]);  // 512 bytes

endmodule

// File: hw/sram_bridge.sv
// sram bank mapper and pin driver
`timescale 1ns/1ps

module sram_bridge (
	input  logic [3:0] sel_chip_i,
	input  logic [2:0] sel_slow_i,
	input  logic sel_kick_i,
	input  logic [chipset_pkg::ADDR_W-1:0] address_i,
	input  logic rd_i,
	input  logic hwr_i,
	input  logic lwr_i,
	input  logic [chipset_pkg::DATA_W-1:0] wdata_i,
	input  logic [chipset_pkg::DATA_W-1:0] ram_rdata_i,
	output logic [chipset_pkg::RAM_ADDR_W-1:0] ram_address_o,
	output logic [chipset_pkg::DATA_W-1:0] ram_wdata_o,
	output logic _ram_we_o,
	output logic _ram_oe_o,
	output logic _ram_bhe_o,
	output logic _ram_ble_o,
	output logic [chipset_pkg::DATA_W-1:0] rd_data_o
);

	localparam int BANK_IDX_W = $clog2(chipset_pkg::BANK_W);    // 3
	localparam int OFFS_W = chipset_pkg::RAM_ADDR_W - BANK_IDX_W;  // word offset in bank

	logic [chipset_pkg::BANK_W-1:0] bank;  // one-hot
	logic [BANK_IDX_W-1:0] bank_num;
	logic bank_hit;
	logic ram_read;

	// ----------------------------------------------------------
	// region selects onto banks
	// ----------------------------------------------------------
	always_comb begin
		bank = '0;
		bank[chipset_pkg::BANK_SLOW0-1:0] = sel_chip_i;  // chip n -> bank n
		bank[chipset_pkg::BANK_SLOW0 +: 3] = sel_slow_i;
		bank[chipset_pkg::BANK_KICK] = sel_kick_i;
	end

	// one-hot to bank index
	always_comb begin
		bank_num = '0;
		for (int b = 0; b < chipset_pkg::BANK_W; b++) begin
			if (bank[b])
				bank_num = BANK_IDX_W'(b);
		end
	end

	assign bank_hit = |bank;  // unmapped accesses leave the sram alone
	assign ram_read = rd_i & bank_hit;

	// ----------------------------------------------------------
	// sram pins
	// ----------------------------------------------------------
	assign ram_address_o = {bank_num, address_i[OFFS_W-1:0]};  // bank, then a18..a1
	assign ram_wdata_o = wdata_i;
	assign _ram_oe_o  = ~ram_read;
	assign _ram_we_o  = ~(bank_hit & (hwr_i | lwr_i));
	assign _ram_bhe_o = ~(bank_hit & (hwr_i | rd_i));  // both lanes on a read
	assign _ram_ble_o = ~(bank_hit & (lwr_i | rd_i));

	// quiet bus unless we are reading, bridge ORs sources
	assign rd_data_o = ram_read ? ram_rdata_i : '0;

endmodule

// File: hw/irq_controller.sv
// interrupt enable, request and priority
`timescale 1ns/1ps

module irq_controller (
	input  logic clk,
	input  logic reset,
	input  logic sel_reg_i,
	input  logic [7:0] reg_offset_i,  // register word offset
	input  logic rd_i,
	input  logic hwr_i,
	input  logic lwr_i,
	input  logic [chipset_pkg::DATA_W-1:0] wdata_i,
	input  logic [chipset_pkg::IRQ_W-1:0] irq_src_i,  // one clock pulses
	input  logic nmi_i,
	output logic [chipset_pkg::DATA_W-1:0] reg_rd_data_o,
	output logic [2:0] _ipl_o
);

	logic [chipset_pkg::INTEN_BIT:0] intena;  // sources plus master enable
	logic [chipset_pkg::IRQ_W-1:0] intreq;
	logic [chipset_pkg::IRQ_W-1:0] intreq_nxt;
	logic [chipset_pkg::IRQ_W-1:0] active;    // requested and enabled
	logic [chipset_pkg::DATA_W-1:0] wr_bits;  // written lanes only
	logic reg_wr, wr_intena, wr_intreq, setclr;
	logic [2:0] level;

	// ----------------------------------------------------------
	// register writes, set/clear style
	// ----------------------------------------------------------
	assign reg_wr    = sel_reg_i & (hwr_i | lwr_i);
	assign wr_bits   = wdata_i & {{8{hwr_i}}, {8{lwr_i}}};
	assign setclr    = wr_bits[chipset_pkg::SETCLR_BIT];
	assign wr_intena = reg_wr & (reg_offset_i == chipset_pkg::INTENA[8:1]);
	assign wr_intreq = reg_wr & (reg_offset_i == chipset_pkg::INTREQ[8:1]);

	always_comb begin
		intreq_nxt = intreq;
		if (wr_intreq)
			intreq_nxt = setclr ? (intreq | wr_bits[chipset_pkg::IRQ_W-1:0])
				: (intreq & ~wr_bits[chipset_pkg::IRQ_W-1:0]);
		intreq_nxt = intreq_nxt | irq_src_i;  // source wins over a clear
	end

	// ----------------------------------------------------------
	// priority encoder, later lines override earlier ones
	// ----------------------------------------------------------
	assign active = intreq & intena[chipset_pkg::IRQ_W-1:0]
		& {chipset_pkg::IRQ_W{intena[chipset_pkg::INTEN_BIT]}};

	always_comb begin
		level = 3'd0;
		if (|active[2:0])   level = 3'd1;
		if (active[3])      level = 3'd2;
		if (|active[6:4])   level = 3'd3;
		if (|active[10:7])  level = 3'd4;
		if (|active[12:11]) level = 3'd5;
		if (active[13])     level = 3'd6;
		if (nmi_i)          level = 3'd7;  // cartridge freeze
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			intena <= '0;
			intreq <= '0;
			_ipl_o <= 3'b111;  // no interrupt
		end else begin
			if (wr_intena)
				intena <= setclr ? (intena | wr_bits[chipset_pkg::INTEN_BIT:0])
					: (intena & ~wr_bits[chipset_pkg::INTEN_BIT:0]);
			intreq <= intreq_nxt;
			_ipl_o <= ~level;
		end
	end

	// readback, bit 15 always reads zero
	always_comb begin
		reg_rd_data_o = '0;
		if (sel_reg_i && rd_i && reg_offset_i == chipset_pkg::INTENAR[8:1])
			reg_rd_data_o = {1'b0, intena};
		else if (sel_reg_i && rd_i && reg_offset_i == chipset_pkg::INTREQR[8:1])
			reg_rd_data_o = {{(chipset_pkg::DATA_W - chipset_pkg::IRQ_W){1'b0}}, intreq};
	end

endmodule

// File: hw/reset_ctrl.sv
// frame counted reset hold
`timescale 1ns/1ps

module reset_ctrl #(
	parameter int RESET_FRAMES = 3  // frames to wait after a request
) (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext_i,      // async, active high
	input  logic kbd_reset_n_i,  // async, active low
	input  logic sof_i,
	output logic chip_reset_o,
	output logic _cpu_reset_o,
	output logic rst_out_o
);

	localparam int CNT_W = $clog2(RESET_FRAMES + 1);

	logic [1:0] ext_sync;   // two flop synchronizers
	logic [1:0] kbd_sync;
	logic req;
	logic [CNT_W-1:0] frame_cnt;
	logic hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			ext_sync <= 2'b00;
			kbd_sync <= 2'b11;  // idle is high
		end else begin
			ext_sync <= {ext_sync[0], rst_ext_i};
			kbd_sync <= {kbd_sync[0], kbd_reset_n_i};
		end
	end

	assign req = ext_sync[1] | ~kbd_sync[1];

	// ----------------------------------------------------------
	// hold counter, restarts on any request
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || req) begin
			frame_cnt <= '0;
			hold <= 1'b1;
		end else if (hold && sof_i) begin
			frame_cnt <= frame_cnt + 1'b1;
			if (frame_cnt == CNT_W'(RESET_FRAMES - 1))
				hold <= 1'b0;  // last frame seen
		end
	end

	assign chip_reset_o = hold;
	assign rst_out_o    = hold;
	assign _cpu_reset_o = ~hold;

endmodule

// File: hw/chipset_bus_top.sv
// chipset bus subsystem top
`timescale 1ns/1ps

module chipset_bus_top #(
	parameter int ACCESS_CYCLES = 2,  // strobe length in clocks
	parameter int RESET_FRAMES  = 3   // frames of reset hold
) (
	input  logic clk,
	input  logic reset,
	// cpu side
	input  logic _cpu_as_i,
	input  logic _cpu_uds_i,
	input  logic _cpu_lds_i,
	input  logic cpu_r_w_i,
	input  logic [chipset_pkg::ADDR_W-1:0] cpu_address_i,
	input  logic [chipset_pkg::DATA_W-1:0] cpu_wdata_i,
	output logic [chipset_pkg::DATA_W-1:0] cpu_rdata_o,
	output logic _cpu_dtack_o,
	output logic [2:0] _ipl_o,
	output logic _cpu_reset_o,
	// sram side
	output logic [chipset_pkg::RAM_ADDR_W-1:0] ram_address_o,
	output logic [chipset_pkg::DATA_W-1:0] ram_wdata_o,
	input  logic [chipset_pkg::DATA_W-1:0] ram_rdata_i,
	output logic _ram_we_o,
	output logic _ram_oe_o,
	output logic _ram_bhe_o,
	output logic _ram_ble_o,
	// configuration and system
	input  logic [3:0] memory_config_i,  // [1:0] chip banks-1, [3:2] slow banks
	input  logic ovl_i,                  // kickstart overlay
	input  logic [chipset_pkg::IRQ_W-1:0] irq_src_i,
	input  logic nmi_i,                  // level 7 request from cartridge
	input  logic sof_i,                  // start of frame pulse
	input  logic rst_ext_i,
	input  logic kbd_reset_n_i,
	output logic rst_out_o
);

	// ----------------------------------------------------------
	// internal wiring
	// ----------------------------------------------------------
	logic chip_reset;  // reset for everything below reset_ctrl
	logic rd, hwr, lwr;  // bus strobes from the bridge
	logic [3:0] sel_chip;
	logic [2:0] sel_slow;
	logic sel_kick, sel_reg;
	logic [chipset_pkg::DATA_W-1:0] ram_rd_data;  // zero unless sram read
	logic [chipset_pkg::DATA_W-1:0] reg_rd_data;  // zero unless reg read

	cpu_bus_bridge #(.ACCESS_CYCLES(ACCESS_CYCLES)) i_bridge (
		.clk(clk), .reset(chip_reset),
		._cpu_as_i(_cpu_as_i), ._cpu_uds_i(_cpu_uds_i), ._cpu_lds_i(_cpu_lds_i),
		.cpu_r_w_i(cpu_r_w_i), .ram_rd_data_i(ram_rd_data), .reg_rd_data_i(reg_rd_data),
		.rd_o(rd), .hwr_o(hwr), .lwr_o(lwr),
		.cpu_rdata_o(cpu_rdata_o), ._cpu_dtack_o(_cpu_dtack_o)
	);

	address_decoder i_decoder (
		.address_i(cpu_address_i), .rd_i(rd),
		.memory_config_i(memory_config_i), .ovl_i(ovl_i),
		.sel_chip_o(sel_chip), .sel_slow_o(sel_slow),
		.sel_kick_o(sel_kick), .sel_reg_o(sel_reg)
	);

	sram_bridge i_sram (
		.sel_chip_i(sel_chip), .sel_slow_i(sel_slow), .sel_kick_i(sel_kick),
		.address_i(cpu_address_i), .rd_i(rd), .hwr_i(hwr), .lwr_i(lwr),
		.wdata_i(cpu_wdata_i), .ram_rdata_i(ram_rdata_i),
		.ram_address_o(ram_address_o), .ram_wdata_o(ram_wdata_o),
		._ram_we_o(_ram_we_o), ._ram_oe_o(_ram_oe_o),
		._ram_bhe_o(_ram_bhe_o), ._ram_ble_o(_ram_ble_o), .rd_data_o(ram_rd_data)
	);

	irq_controller i_irq (
		.clk(clk), .reset(chip_reset), .sel_reg_i(sel_reg),
		.reg_offset_i(cpu_address_i[7:0]),  // byte address bits 8..1
		.rd_i(rd), .hwr_i(hwr), .lwr_i(lwr), .wdata_i(cpu_wdata_i),
		.irq_src_i(irq_src_i), .nmi_i(nmi_i),
		.reg_rd_data_o(reg_rd_data), ._ipl_o(_ipl_o)
	);

	reset_ctrl #(.RESET_FRAMES(RESET_FRAMES)) i_reset (
		.clk(clk), .reset(reset), .rst_ext_i(rst_ext_i),
		.kbd_reset_n_i(kbd_reset_n_i), .sof_i(sof_i),
		.chip_reset_o(chip_reset), ._cpu_reset_o(_cpu_reset_o), .rst_out_o(rst_out_o)
	);

endmodule

// File: test/tb_clock_gen.sv
// testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD = 40.0  // ns
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2.0) clk_o = ~clk_o;
	end

endmodule

// File: test/tb_chipset_bus.sv
// chipset bus testbench
`timescale 1ns/1ps

module tb_chipset_bus;

	localparam int ACCESS_CYCLES = 2;
	localparam int RESET_FRAMES  = 3;
	localparam int WAIT_LIMIT    = 64;  // cycles before any wait gives up
	localparam int HOLD_EXTRA    = 2;   // cpu keeps as low this long after dtack

	logic clk, reset;
	logic _cpu_as, _cpu_uds, _cpu_lds, cpu_r_w;
	logic [chipset_pkg::ADDR_W-1:0] cpu_address;
	logic [chipset_pkg::DATA_W-1:0] cpu_wdata, cpu_rdata, ram_wdata, ram_rdata;
	logic _cpu_dtack, _cpu_reset, rst_out;
	logic [2:0] _ipl;
	logic [chipset_pkg::RAM_ADDR_W-1:0] ram_address;
	logic _ram_we, _ram_oe, _ram_bhe, _ram_ble;
	logic [3:0] memory_config;
	logic ovl, nmi, sof, rst_ext, kbd_reset_n;
	logic [chipset_pkg::IRQ_W-1:0] irq_src;

	int errors, timeouts;
	logic [31:0] lfsr_state;
	// sram pins seen during the last bus cycle
	int we_cnt, oe_cnt;
	logic [chipset_pkg::RAM_ADDR_W-1:0] cap_addr;
	logic [15:0] cap_wdata, bus_rdata;
	logic cap_bhe, cap_ble;

	tb_clock_gen #(.PERIOD(40.0)) i_clock (.clk_o(clk));

	chipset_bus_top #(.ACCESS_CYCLES(ACCESS_CYCLES), .RESET_FRAMES(RESET_FRAMES)) i_dut (
		.clk(clk), .reset(reset),
		._cpu_as_i(_cpu_as), ._cpu_uds_i(_cpu_uds), ._cpu_lds_i(_cpu_lds),
		.cpu_r_w_i(cpu_r_w), .cpu_address_i(cpu_address), .cpu_wdata_i(cpu_wdata),
		.cpu_rdata_o(cpu_rdata), ._cpu_dtack_o(_cpu_dtack), ._ipl_o(_ipl),
		._cpu_reset_o(_cpu_reset),
		.ram_address_o(ram_address), .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
		._ram_we_o(_ram_we), ._ram_oe_o(_ram_oe), ._ram_bhe_o(_ram_bhe), ._ram_ble_o(_ram_ble),
		.memory_config_i(memory_config), .ovl_i(ovl), .irq_src_i(irq_src), .nmi_i(nmi),
		.sof_i(sof), .rst_ext_i(rst_ext), .kbd_reset_n_i(kbd_reset_n), .rst_out_o(rst_out)
	);

	// ----------------------------------------------------------
	// random numbers and reference rules
	// ----------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);  // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [23:0] region_addr(input logic slow, input logic [1:0] bank,
			input logic [17:0] offset);
		logic [23:0] base;
		base = slow ? chipset_pkg::SLOW_BASE : chipset_pkg::CHIP_BASE;
		return base + {3'b000, bank, offset, 1'b0};  // 512KB banks
	endfunction

	function automatic logic [23:0] reg_addr(input logic [8:0] offset);
		return chipset_pkg::REG_BASE + {15'd0, offset};
	endfunction

	function automatic logic [2:0] level_of_bit(input int b);
		if (b <= 2) return 3'd1;
		if (b == 3) return 3'd2;
		if (b <= 6) return 3'd3;
		if (b <= 10) return 3'd4;
		if (b <= 12) return 3'd5;
		return 3'd6;
	endfunction

	// ipl for requests with every source and the master bit enabled
	function automatic logic [2:0] expected_ipl(input logic [13:0] req, input logic nmi_req);
		logic [2:0] top;
		top = nmi_req ? 3'd7 : 3'd0;
		for (int b = 0; b < chipset_pkg::IRQ_W; b++) begin
			if (req[b] && level_of_bit(b) > top)
				top = level_of_bit(b);
		end
		return ~top;
	endfunction

	// ----------------------------------------------------------
	// checking and bus tasks
	// ----------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual)
		else begin
			errors++;
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;  // drive point
	endtask

	task automatic capture_pins();
		if (!_ram_we) begin
			we_cnt++;
			cap_addr = ram_address;
			cap_wdata = ram_wdata;
			cap_bhe = _ram_bhe;
			cap_ble = _ram_ble;
		end
		if (!_ram_oe) begin
			oe_cnt++;
			cap_addr = ram_address;
			cap_bhe = _ram_bhe;
			cap_ble = _ram_ble;
		end
	endtask

	// one full 68000 cycle, checks the dtack handshake on the way
	task automatic bus_cycle(input string name, input logic wr, input logic [23:0] byte_addr,
			input logic [15:0] data, input logic [1:0] lanes);
		int edges;
		we_cnt = 0;
		oe_cnt = 0;
		_cpu_as = 1'b0;
		cpu_r_w = ~wr;
		cpu_address = byte_addr[23:1];
		cpu_wdata = data;
		_cpu_uds = ~lanes[1];
		_cpu_lds = ~lanes[0];
		@(posedge clk);  // edge 0
		edges = 0;
		@(negedge clk);
		while (_cpu_dtack === 1'b1 && edges < WAIT_LIMIT) begin
			capture_pins();
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		if (_cpu_dtack !== 1'b0) begin
			timeouts++;
			$display("Timeout: %s got no dtack", name);
		end
		check_value({name, " dtack edge"}, ACCESS_CYCLES + 1, edges);
		bus_rdata = cpu_rdata;
		for (int i = 0; i < HOLD_EXTRA; i++) begin
			@(negedge clk);
			check_value({name, " dtack held"}, 0, _cpu_dtack);
		end
		next_cycle();
		_cpu_as = 1'b1;  // release
		_cpu_uds = 1'b1;
		_cpu_lds = 1'b1;
		cpu_r_w = 1'b1;
		edges = 0;
		while (_cpu_dtack !== 1'b1 && edges < WAIT_LIMIT) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		if (_cpu_dtack !== 1'b1) begin
			timeouts++;
			$display("Timeout: %s dtack never rose", name);
		end
		check_value({name, " dtack release"}, 1, edges);
		next_cycle();
	endtask

	// ----------------------------------------------------------
	// reset hold
	// ----------------------------------------------------------
	task automatic run_frames(input string name);
		for (int f = 1; f <= RESET_FRAMES; f++) begin
			repeat (3) next_cycle();  // no frame yet, must hold
			@(negedge clk);
			check_value({name, " hold"}, 1, rst_out);
			check_value({name, " cpu reset inverse"}, 1, rst_out ^ _cpu_reset);
			next_cycle();
			sof = 1'b1;
			next_cycle();
			sof = 1'b0;
			@(negedge clk);
			check_value({name, " frame count"}, f < RESET_FRAMES, rst_out);
			check_value({name, " cpu reset inverse"}, 1, rst_out ^ _cpu_reset);
		end
		next_cycle();
	endtask

	task automatic request_reset(input string name, input logic from_kbd);
		int waited;
		@(negedge clk);
		check_value({name, " idle"}, 0, rst_out);
		next_cycle();
		if (from_kbd)
			kbd_reset_n = 1'b0;
		else
			rst_ext = 1'b1;
		waited = 0;
		@(negedge clk);
		while (rst_out !== 1'b1 && waited < WAIT_LIMIT) begin  // through the synchronizer
			@(negedge clk);
			waited++;
		end
		if (rst_out !== 1'b1) begin
			timeouts++;
			$display("Timeout: %s never raised rst_out", name);
		end
		next_cycle();
		kbd_reset_n = 1'b1;
		rst_ext = 1'b0;
		run_frames(name);
	endtask

	// ----------------------------------------------------------
	// memory tests
	// ----------------------------------------------------------
	task automatic ram_write_read(input int rounds);
		logic slow;
		logic [1:0] bank, lanes;
		logic [17:0] offset;
		logic [15:0] data;
		logic [20:0] exp_addr;
		for (int r = 0; r < rounds; r++) begin
			slow = rand_bits(1);
			bank = rand_bits(2);
			if (slow && bank == 2'd3)
				bank = 2'd2;  // three slow banks at most
			offset = rand_bits(18);
			data = rand_bits(16);
			lanes = rand_bits(2);
			if (lanes == 2'b00)
				lanes = 2'b11;
			exp_addr = {slow ? 3'(chipset_pkg::BANK_SLOW0 + bank) : {1'b0, bank}, offset};
			bus_cycle("ram write", 1'b1, region_addr(slow, bank, offset), data, lanes);
			check_value("ram write we pulses", 1, we_cnt);
			check_value("ram write oe", 0, oe_cnt);
			check_value("ram write address", exp_addr, cap_addr);
			check_value("ram write data", data, cap_wdata);
			check_value("ram write lanes", 2'(~lanes), {cap_bhe, cap_ble});
			ram_rdata = rand_bits(16);
			bus_cycle("ram read", 1'b0, region_addr(slow, bank, offset), 16'h0, 2'b11);
			check_value("ram read oe cycles", ACCESS_CYCLES, oe_cnt);
			check_value("ram read address", exp_addr, cap_addr);
			check_value("ram read lanes", 0, {cap_bhe, cap_ble});
			check_value("ram read data", ram_rdata, bus_rdata);
		end
	endtask

	task automatic check_unmapped(input string name, input logic [23:0] byte_addr);
		bus_cycle(name, 1'b1, byte_addr, 16'h5a5a, 2'b11);
		check_value({name, " write strobes"}, 0, we_cnt);
		ram_rdata = 16'ha5c3;  // must not reach the cpu
		bus_cycle(name, 1'b0, byte_addr, 16'h0, 2'b11);
		check_value({name, " read strobes"}, 0, oe_cnt);
		check_value({name, " read data"}, 0, bus_rdata);
	endtask

	task automatic sizing_and_overlay();
		memory_config = 4'b0100;  // one chip bank, one slow bank
		check_unmapped("chip bank 1 unsized", region_addr(1'b0, 2'd1, rand_bits(18)));
		check_unmapped("slow bank 1 unsized", region_addr(1'b1, 2'd1, rand_bits(18)));
		memory_config = 4'b0000;
		check_unmapped("slow ram absent", region_addr(1'b1, 2'd0, rand_bits(18)));
		// overlay, rom on reads only
		ovl = 1'b1;
		ram_rdata = rand_bits(16);
		bus_cycle("overlay read", 1'b0, 24'h000000, 16'h0, 2'b11);
		check_value("overlay read bank", {3'(chipset_pkg::BANK_KICK), 18'd0}, cap_addr);
		check_value("overlay read data", ram_rdata, bus_rdata);
		bus_cycle("overlay write", 1'b1, 24'h000000, 16'h1234, 2'b11);
		check_value("overlay write we pulses", 1, we_cnt);
		check_value("overlay write bank", 0, cap_addr);
		ovl = 1'b0;
	endtask

	// ----------------------------------------------------------
	// interrupts
	// ----------------------------------------------------------
	task automatic pulse_source(input logic [13:0] bits);
		irq_src = bits;
		next_cycle();  // request bit set here
		irq_src = '0;
		next_cycle();  // ipl register follows
	endtask

	task automatic check_ipl(input string name, input logic [2:0] expected);
		@(negedge clk);
		check_value(name, expected, _ipl);
		next_cycle();
	endtask

	task automatic interrupt_checks(input int rounds);
		logic [13:0] src;
		bus_cycle("intena write", 1'b1, reg_addr(chipset_pkg::INTENA), 16'hc008, 2'b11);
		pulse_source(14'h0008);
		check_ipl("ipl source 3", 3'd5);
		ram_rdata = 16'hffff;
		bus_cycle("intreqr read", 1'b0, reg_addr(chipset_pkg::INTREQR), 16'h0, 2'b11);
		check_value("intreqr read", 16'h0008, bus_rdata);
		bus_cycle("intreq clear", 1'b1, reg_addr(chipset_pkg::INTREQ), 16'h0008, 2'b11);
		check_ipl("ipl after clear", 3'd7);
		nmi = 1'b1;
		next_cycle();
		check_ipl("ipl nmi", expected_ipl(14'h0000, nmi));
		nmi = 1'b0;
		// everything on, then random sources
		bus_cycle("intena all", 1'b1, reg_addr(chipset_pkg::INTENA), 16'hffff, 2'b11);
		for (int r = 0; r < rounds; r++) begin
			bus_cycle("intreq clear all", 1'b1, reg_addr(chipset_pkg::INTREQ), 16'h3fff, 2'b11);
			src = rand_bits(14);
			pulse_source(src);
			check_ipl("ipl random sources", expected_ipl(src, 1'b0));
		end
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		errors = 0;
		timeouts = 0;
		lfsr_state = 32'hf02c;
		reset = 1'b1;
		_cpu_as = 1'b1;
		_cpu_uds = 1'b1;
		_cpu_lds = 1'b1;
		cpu_r_w = 1'b1;
		cpu_address = '0;
		cpu_wdata = '0;
		ram_rdata = '0;
		memory_config = 4'b1111;  // full chip and slow ram
		ovl = 1'b0;
		irq_src = '0;
		nmi = 1'b0;
		sof = 1'b0;
		rst_ext = 1'b0;
		kbd_reset_n = 1'b1;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;
		@(negedge clk);
		check_value("reset outputs", 8'hff, {_cpu_dtack, _ram_we, _ram_oe, _ram_bhe, _ram_ble, _ipl});
		next_cycle();
		run_frames("power-on");
		request_reset("keyboard reset", 1'b1);
		request_reset("external reset", 1'b0);
		ram_write_read(12);
		sizing_and_overlay();
		interrupt_checks(10);
		$display("Checks done: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: project.f
hw/chipset_pkg.sv
hw/cpu_bus_bridge.sv
hw/address_decoder.sv
hw/sram_bridge.sv
hw/irq_controller.sv
hw/reset_ctrl.sv
hw/chipset_bus_top.sv
test/tb_clock_gen.sv
test/tb_chipset_bus.sv

// File: Bender.yml
package:
  name: chipset_bus

sources:
  - hw/chipset_pkg.sv
  - hw/cpu_bus_bridge.sv
  - hw/address_decoder.sv
  - hw/sram_bridge.sv
  - hw/irq_controller.sv
  - hw/reset_ctrl.sv
  - hw/chipset_bus_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_chipset_bus.sv
